/* dv/clock_gen.sv */
// testbench clock, 100 ns period, and active low reset generator

`timescale 1ns/100ps

module clock_gen
(
  input  logic hold_rst,
  output logic clock,
  output logic arst_n
);

  int por_cnt;

  initial
  begin
    clock   = 1'b0;
    arst_n  = 1'b0;
    por_cnt = 0;
  end

  always #50 clock = ~clock;

  // power-on reset for 5 rising edges, then follows hold_rst
  always @(posedge clock)
  begin
    if (por_cnt < 5)
      por_cnt = por_cnt + 1;
    arst_n <= (por_cnt >= 5) && !hold_rst;
  end

endmodule

/* dv/gb_lite_tb.sv */
// board testbench with cartridge ROM model, random program builder,
// reference interpreter and the register, store and work RAM comparison

`timescale 1ns/100ps

module gb_lite_tb
  import board_bus_pkg::*;
();

  logic        clock, arst_n, hold_rst;
  logic [7:0]  cart_data;
  logic [15:0] A, pc, af, bc, de, hl;
  logic [7:0]  Do;
  logic        rd_n, wr_n, cs_n, halted;

  logic [7:0]  rom [ROM_DEPTH];
  logic [31:0] lfsr_q;
  int          wp, errors, checks;
  logic [63:0] exp_regs;
  logic [15:0] ref_pc;
  logic [7:0]  ref_ram [256];
  logic        ref_written [256];
  logic [23:0] exp_stores [$];
  logic [23:0] store_exp;
  event        compare_ev;
  logic        cmp_done;

  clock_gen u_clk (.hold_rst, .clock, .arst_n);

  gb_lite_top DUT (
    .clock, .arst_n, .cart_data, .A, .Do, .rd_n, .wr_n, .cs_n,
    .pc, .af, .bc, .de, .hl, .halted
  );

  // cartridge ROM read combinationally from the address bus
  always_comb cart_data = rom[A[14:0]];

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // never the (HL) slot and H only as a source
  function automatic logic [2:0] pick_reg(input logic allow_h);
    logic [2:0] r;
    r = 3'(take_bits(3));
    while (r == 3'd6 || (!allow_h && r == 3'd4))
      r = 3'(take_bits(3));
    return r;
  endfunction

  task automatic emit_byte(input logic [7:0] b);
    rom[wp] = b;
    wp++;
  endtask

  // mix 0 loads only, 1 ALU and INC/DEC, 2 anything
  task automatic emit_random_op(input int mix);
    int         k;
    logic [2:0] op;
    k = take_bits(2);
    if (mix == 0)
      k = k % 2;
    else if (mix == 1)
      k = 2 + k % 2;
    case (k)
      0:
      begin
        emit_byte({2'b00, pick_reg(1'b0), 3'b110});
        emit_byte(8'(take_bits(8)));
      end
      1: emit_byte({2'b01, pick_reg(1'b0), pick_reg(1'b1)});
      2:
      begin
        // ADC and SBC are outside the subset
        op = 3'(take_bits(3));
        while (op == 3'd1 || op == 3'd3)
          op = 3'(take_bits(3));
        emit_byte({2'b10, op, pick_reg(1'b1)});
      end
      default: emit_byte({2'b00, pick_reg(1'b0), 2'b10, 1'(take_bits(1))});
    endcase
  endtask

  // store at x, store at y, reload x then y
  task automatic emit_round_trip();
    logic [7:0] x, y;
    x = 8'(take_bits(8));
    y = x + 8'd1 + 8'(take_bits(7));
    emit_byte(8'h3E);
    emit_byte(8'(take_bits(8)));
    emit_byte(8'h2E);
    emit_byte(x);
    emit_byte(8'h77);
    emit_byte(8'h3E);
    emit_byte(8'(take_bits(8)));
    emit_byte(8'h2E);
    emit_byte(y);
    emit_byte(8'h77);
    emit_random_op(1);
    emit_byte(8'h2E);
    emit_byte(x);
    emit_byte(8'h7E);
    emit_byte(8'h47);
    emit_byte(8'h2E);
    emit_byte(y);
    emit_byte(8'h7E);
  endtask

  // forward JP over INC A filler
  task automatic emit_jump();
    int nfill, target;
    nfill  = 2 + take_bits(2);
    target = wp + 3 + nfill;
    emit_byte(8'hC3);
    emit_byte(8'(target));
    emit_byte(8'(target >> 8));
    repeat (nfill) emit_byte(8'h3C);
  endtask

  task automatic gen_program(input int kind);
    for (int a = 0; a < ROM_DEPTH; a++)
      rom[a] = 8'(a) ^ 8'(a >> 7);
    wp = 0;
    // LD H,0x40 points HL into work RAM
    emit_byte(8'h26);
    emit_byte(8'h40);
    case (kind)
      0: repeat (12) emit_random_op(0);
      1:
      begin
        // LD r,d8 for B C D E L A before the ALU run
        for (int r = 0; r < 8; r++)
          if (r != 4 && r != 6)
          begin
            emit_byte({2'b00, 3'(r), 3'b110});
            emit_byte(8'(take_bits(8)));
          end
        repeat (16) emit_random_op(1);
      end
      2: repeat (2) emit_round_trip();
      default:
      begin
        repeat (3) emit_random_op(2);
        emit_jump();
        repeat (3) emit_random_op(2);
        emit_jump();
        repeat (3) emit_random_op(2);
      end
    endcase
    emit_byte(8'h76);
  endtask

  // kind is the ALU y code, or 8 for INC and 9 for DEC
  // returns {result, F}
  function automatic logic [15:0] ref_alu(input int kind, input logic [7:0] a,
                                          input logic [7:0] b, input logic [7:0] f_in);
    logic [8:0] t;
    logic [7:0] r;
    logic       n, h, c;
    n = 1'b0;
    h = 1'b0;
    c = f_in[4];
    r = b;
    case (kind)
      0:
      begin
        t = {1'b0, a} + {1'b0, b};
        r = t[7:0];
        h = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
        c = t[8];
      end
      2, 7:
      begin
        r = a - b;
        n = 1'b1;
        h = a[3:0] < b[3:0];
        c = a < b;
      end
      4:
      begin
        r = a & b;
        h = 1'b1;
        c = 1'b0;
      end
      5:
      begin
        r = a ^ b;
        c = 1'b0;
      end
      6:
      begin
        r = a | b;
        c = 1'b0;
      end
      8:
      begin
        r = b + 8'd1;
        h = b[3:0] == 4'hF;
      end
      9:
      begin
        r = b - 8'd1;
        n = 1'b1;
        h = b[3:0] == 4'h0;
      end
      default: r = b;
    endcase
    return {r, r == 8'h00, n, h, c, 4'h0};
  endfunction

  // interprets the ROM image and returns {AF, BC, DE, HL}
  // RAM image in ref_ram, bus stores in exp_stores, final PC in ref_pc
  function automatic logic [63:0] gb_ref_run();
    logic [7:0]  r [8];
    logic [7:0]  f, op, lo;
    logic [15:0] p, alu;
    int          steps;
    logic        done;
    for (int i = 0; i < 8; i++)
      r[i] = 8'h00;
    for (int i = 0; i < 256; i++)
    begin
      ref_ram[i]     = 8'h00;
      ref_written[i] = 1'b0;
    end
    exp_stores.delete();
    f     = 8'h00;
    p     = RESET_PC;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 4000)
    begin
      steps++;
      op = rom[p[14:0]];
      p++;
      if (op == 8'h76)
        done = 1'b1;
      else if (op == 8'hC3)
      begin
        lo = rom[p[14:0]];
        p  = {rom[15'(p + 16'd1)], lo};
      end
      else
        case (op[7:6])
          2'd0:
            if (op[2:0] == 3'd6 && op[5:3] != 3'd6)
            begin
              r[op[5:3]] = rom[p[14:0]];
              p++;
            end
            else if ((op[2:0] == 3'd4 || op[2:0] == 3'd5) && op[5:3] != 3'd6)
            begin
              alu        = ref_alu(op[0] ? 9 : 8, r[7], r[op[5:3]], f);
              r[op[5:3]] = alu[15:8];
              f          = alu[7:0];
            end
          2'd1:
            if (op == 8'h77)
            begin
              ref_ram[r[5]]     = r[7];
              ref_written[r[5]] = 1'b1;
              // store goes to HL with A as data
              exp_stores.push_back({r[4], r[5], r[7]});
            end
            else if (op == 8'h7E)
              r[7] = ref_ram[r[5]];
            else if (op[5:3] != 3'd6 && op[2:0] != 3'd6)
              r[op[5:3]] = r[op[2:0]];
          2'd2:
            if (op[2:0] != 3'd6 && op[5:3] != 3'd1 && op[5:3] != 3'd3)
            begin
              alu = ref_alu(int'(op[5:3]), r[7], r[op[2:0]], f);
              // CP only touches F
              if (op[5:3] != 3'd7)
                r[7] = alu[15:8];
              f = alu[7:0];
            end
          default: ;
        endcase
    end
    ref_pc = p;
    return {r[7], f, r[0], r[1], r[2], r[3], r[4], r[5]};
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // each bus store against the next store of the reference, in order
  always @(negedge clock)
  begin
    if (wr_n === 1'b0)
    begin
      assert (exp_stores.size() != 0)
      else
      begin
        $display("store to 0x%04h that the reference never makes", A);
        errors++;
      end
      if (exp_stores.size() != 0)
      begin
        store_exp = exp_stores.pop_front();
        check_val("A", A, store_exp[23:8]);
        check_val("Do", Do, store_exp[7:0]);
      end
    end
  end

  // comparison against the reference once the DUT has halted
  always @(compare_ev)
  begin
    check_val("af", af, exp_regs[63:48]);
    check_val("bc", bc, exp_regs[47:32]);
    check_val("de", de, exp_regs[31:16]);
    check_val("hl", hl, exp_regs[15:0]);
    check_val("pc", pc, ref_pc);
    for (int i = 0; i < 256; i++)
      if (ref_written[i])
        check_val($sformatf("wram[%02h]", i), DUT.u_wram.mem[i], ref_ram[i]);
    assert (exp_stores.size() == 0)
    else
    begin
      $display("%0d stores of the reference never reached the bus", exp_stores.size());
      errors++;
    end
    cmp_done = 1'b1;
  end

  task automatic wait_reset_level(input logic level);
    int n;
    n = 0;
    while (arst_n !== level && n < 20)
    begin
      @(negedge clock);
      n++;
    end
    assert (arst_n === level)
    else
    begin
      $display("reset did not reach level %0b in time", level);
      errors++;
    end
  endtask

  task automatic wait_halted(input int idx);
    int n;
    n = 0;
    while (!halted && n < 2000)
    begin
      @(negedge clock);
      n++;
    end
    assert (halted)
    else
    begin
      $display("program %0d never halted within 2000 cycles", idx);
      errors++;
    end
  endtask

  task automatic wait_compare();
    int n;
    n = 0;
    while (!cmp_done && n < 10)
    begin
      @(negedge clock);
      n++;
    end
    assert (cmp_done)
    else
    begin
      $display("comparison process did not finish");
      errors++;
    end
  endtask

  task automatic run_program(input int kind, input int idx);
    @(posedge clock);
    hold_rst <= 1'b1;
    wait_reset_level(1'b0);
    gen_program(kind);
    exp_regs = gb_ref_run();
    repeat (5) @(posedge clock);
    // state held by reset
    @(negedge clock);
    check_val("strobes in reset", {rd_n, wr_n, cs_n}, 3'b111);
    check_val("halted in reset", halted, 1'b0);
    check_val("pc in reset", pc, RESET_PC);
    check_val("regs in reset", {af, bc, de, hl}, 64'h0);
    @(posedge clock);
    hold_rst <= 1'b0;
    wait_reset_level(1'b1);
    check_val("pc after reset", pc, RESET_PC);
    check_val("halted after reset", halted, 1'b0);
    check_val("regs after reset", {af, bc, de, hl}, 64'h0);
    wait_halted(idx);
    cmp_done = 1'b0;
    -> compare_ev;
    wait_compare();
    // halted is sticky with an idle bus
    repeat (4)
    begin
      @(negedge clock);
      check_val("halted", halted, 1'b1);
      check_val("strobes after halt", {rd_n, wr_n, cs_n}, 3'b111);
    end
  endtask

  initial
  begin
    hold_rst = 1'b0;
    lfsr_q   = 32'ha3b582fb;
    errors   = 0;
    checks   = 0;
    cmp_done = 1'b0;
    wp       = 0;
    exp_regs = 64'h0;
    ref_pc   = RESET_PC;
    for (int a = 0; a < ROM_DEPTH; a++)
      rom[a] = 8'(a) ^ 8'(a >> 7);
    for (int p = 0; p < 8; p++)
      run_program(p % 4, p);
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* gb_lite.f */
hw/cpu_isa_pkg.sv
hw/board_bus_pkg.sv
hw/sm83_decode.sv
hw/sm83_execute.sv
hw/sm83_result.sv
hw/work_ram.sv
hw/gb_lite_top.sv
dv/clock_gen.sv
dv/gb_lite_tb.sv

/* hw/board_bus_pkg.sv */
// board memory map and the request word each bus master drives

package board_bus_pkg;

  // A[14] set selects work RAM, clear selects cartridge ROM
  localparam int WRAM_SEL_BIT = 14;

  localparam int WRAM_DEPTH = 8192;
  localparam int ROM_DEPTH  = 32768;

  // first opcode fetch address
  localparam logic [15:0] RESET_PC = 16'h0000;

  // one bus master's request for the current cycle
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        rd;
    logic        wr;
  } mem_req_t;

endpackage

/* hw/cpu_isa_pkg.sv */
// SM83 instruction encodings: opcode field views, register index, ALU ops,
// F flag positions, and the decode and execute stage payloads

package cpu_isa_pkg;

  // octal view of an opcode byte, x|y|z
  typedef struct packed {
    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
  } op_xyz_t;

  // same byte with y split into p|q
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] p;
    logic       q;
    logic [2:0] z;
  } op_xpqz_t;

  typedef union packed {
    op_xyz_t  xyz;
    op_xpqz_t xpqz;
  } opcode_u;

  // SM83 register order, index 6 is the (HL) slot
  typedef enum logic [2:0] {
    REG_B      = 3'd0,
    REG_C      = 3'd1,
    REG_D      = 3'd2,
    REG_E      = 3'd3,
    REG_H      = 3'd4,
    REG_L      = 3'd5,
    REG_HL_IND = 3'd6,
    REG_A      = 3'd7
  } reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_OR,
    ALU_CP,
    ALU_INC,
    ALU_DEC,
    ALU_PASS
  } alu_op_t;

  // bit positions in F, low nibble reads as zero
  localparam int FLAG_Z = 7;
  localparam int FLAG_N = 6;
  localparam int FLAG_H = 5;
  localparam int FLAG_C = 4;

  // decode -> execute
  typedef struct packed {
    alu_op_t    alu;
    reg_idx_t   dst;
    reg_idx_t   src;
    logic       imm_valid;
    logic [7:0] imm;
    logic       mem_rd;
    logic       mem_wr;
  } uop_t;

  // execute -> result
  typedef struct packed {
    reg_idx_t   dst;
    logic       we;
    logic [7:0] value;
    logic [7:0] f;
    logic       f_we;
    logic       mem_rd;
    logic       mem_wr;
  } exec_res_t;

endpackage

/* hw/gb_lite_top.sv */
// board top: SM83 decode, execute and result stages, work RAM,
// bus owner select, active low strobes and the data-in mux

`timescale 1ns/100ps

module gb_lite_top
  import cpu_isa_pkg::*;
  import board_bus_pkg::*;
(
  input  logic        clock,
  input  logic        arst_n,
  input  logic [7:0]  cart_data,
  output logic [15:0] A,
  output logic [7:0]  Do,
  output logic        rd_n,
  output logic        wr_n,
  output logic        cs_n,
  output logic [15:0] pc,
  output logic [15:0] af,
  output logic [15:0] bc,
  output logic [15:0] de,
  output logic [15:0] hl,
  output logic        halted
);

  mem_req_t   fetch_req, data_req, bus_req;
  uop_t       uop;
  exec_res_t  res;
  reg_idx_t   rd_src_idx;
  logic       uop_valid, res_valid, exec_stall, bus_busy, halt_seen;
  logic [7:0] rd_a, rd_src, f_out;
  logic [7:0] Di, wram_data;

  // result wins the bus during its (HL) cycle
  assign bus_req = bus_busy ? data_req : fetch_req;
  assign A       = bus_req.addr;
  assign Do      = bus_req.wdata;
  assign rd_n    = !bus_req.rd;
  assign wr_n    = !bus_req.wr;
  assign cs_n    = !(bus_req.rd || bus_req.wr);

  assign Di = A[WRAM_SEL_BIT] ? wram_data : cart_data;

  // halted once nothing is left in flight behind the HALT
  assign halted = halt_seen && !uop_valid && !res_valid && !bus_busy;

  sm83_decode u_decode (
    .clock, .arst_n, .Di, .bus_busy, .exec_stall,
    .fetch_req, .uop, .uop_valid, .pc, .halt_seen
  );

  sm83_execute u_execute (
    .clock, .arst_n, .uop, .uop_valid, .rd_a, .rd_src, .f_in(f_out), .bus_busy,
    .rd_src_idx, .exec_stall, .res, .res_valid
  );

  sm83_result u_result (
    .clock, .arst_n, .res, .res_valid, .Di, .rd_src_idx,
    .data_req, .bus_busy, .rd_a, .rd_src, .f_out, .af, .bc, .de, .hl
  );

  work_ram u_wram (
    .clock,
    .addr  (A[12:0]),
    .wdata (Do),
    .wr_cs (!cs_n && !wr_n && A[WRAM_SEL_BIT]),
    .rd_cs (!cs_n && !rd_n && A[WRAM_SEL_BIT]),
    .rdata (wram_data)
  );

endmodule

/* hw/sm83_decode.sv */
// opcode and immediate fetch, micro-op decode, JP and HALT handling

`timescale 1ns/100ps

module sm83_decode
  import cpu_isa_pkg::*;
  import board_bus_pkg::*;
(
  input  logic        clock,
  input  logic        arst_n,
  input  logic [7:0]  Di,
  input  logic        bus_busy,
  input  logic        exec_stall,
  output mem_req_t    fetch_req,
  output uop_t        uop,
  output logic        uop_valid,
  output logic [15:0] pc,
  output logic        halt_seen
);

  typedef enum logic [2:0] {
    S_START,
    S_OPCODE,
    S_IMM_LO,
    S_IMM_HI,
    S_HALT
  } dec_state_t;

  dec_state_t  st_q, st_d;
  logic [15:0] pc_q, pc_d;
  opcode_u     op_in;
  opcode_u     op_q;
  logic [7:0]  imm_lo_q;
  logic        fetch_en;
  logic        issue;
  uop_t        uop_d;

  // current byte seen through both field views
  assign op_in = Di;

  // no fetch while result owns the bus or execute is full
  assign fetch_en = (st_q != S_START) && (st_q != S_HALT) && !bus_busy && !exec_stall;

  assign fetch_req.addr  = pc_q;
  assign fetch_req.wdata = 8'h00;
  assign fetch_req.rd    = fetch_en;
  assign fetch_req.wr    = 1'b0;

  assign pc        = pc_q;
  assign halt_seen = (st_q == S_HALT);

  always_comb
  begin
    st_d          = st_q;
    pc_d          = pc_q;
    issue         = 1'b0;
    uop_d         = '0;
    uop_d.alu     = ALU_PASS;
    uop_d.src     = REG_A;
    if (fetch_en)
    begin
      pc_d = pc_q + 16'd1;
      case (st_q)
        S_OPCODE:
        begin
          case (op_in.xyz.x)
            2'd0:
            begin
              // LD r,d8 needs one more byte
              if (op_in.xyz.z == 3'd6 && op_in.xyz.y != 3'd6)
                st_d = S_IMM_LO;
              else if ((op_in.xyz.z == 3'd4 || op_in.xyz.z == 3'd5) && op_in.xyz.y != 3'd6)
              begin
                // INC r / DEC r, z[0] picks DEC
                issue     = 1'b1;
                uop_d.alu = op_in.xyz.z[0] ? ALU_DEC : ALU_INC;
                uop_d.dst = reg_idx_t'(op_in.xyz.y);
                uop_d.src = reg_idx_t'(op_in.xyz.y);
              end
            end
            2'd1:
            begin
              if (op_in.xyz.y == 3'd6 && op_in.xyz.z == 3'd6)
                st_d = S_HALT;
              else if (op_in.xpqz.p == 2'd3 && !op_in.xpqz.q && op_in.xpqz.z == 3'd7)
              begin
                // LD (HL),A
                issue        = 1'b1;
                uop_d.dst    = REG_A;
                uop_d.mem_wr = 1'b1;
              end
              else if (op_in.xpqz.p == 2'd3 && op_in.xpqz.q && op_in.xpqz.z == 3'd6)
              begin
                // LD A,(HL)
                issue        = 1'b1;
                uop_d.dst    = REG_A;
                uop_d.mem_rd = 1'b1;
              end
              else if (op_in.xyz.y != 3'd6 && op_in.xyz.z != 3'd6)
              begin
                issue     = 1'b1;
                uop_d.dst = reg_idx_t'(op_in.xyz.y);
                uop_d.src = reg_idx_t'(op_in.xyz.z);
              end
            end
            2'd2:
            begin
              // ALU A,r; ADC, SBC and (HL) operand fall through as NOP
              uop_d.dst = REG_A;
              uop_d.src = reg_idx_t'(op_in.xyz.z);
              issue     = (op_in.xyz.z != 3'd6);
              case (op_in.xyz.y)
                3'd0: uop_d.alu = ALU_ADD;
                3'd2: uop_d.alu = ALU_SUB;
                3'd4: uop_d.alu = ALU_AND;
                3'd5: uop_d.alu = ALU_XOR;
                3'd6: uop_d.alu = ALU_OR;
                3'd7: uop_d.alu = ALU_CP;
                default: issue = 1'b0;
              endcase
            end
            default:
            begin
              // JP a16 only
              if (op_in.xpqz.p == 2'd0 && !op_in.xpqz.q && op_in.xpqz.z == 3'd3)
                st_d = S_IMM_LO;
            end
          endcase
        end
        S_IMM_LO:
        begin
          if (op_q.xyz.x == 2'd0)
          begin
            issue           = 1'b1;
            uop_d.dst       = reg_idx_t'(op_q.xyz.y);
            uop_d.imm_valid = 1'b1;
            uop_d.imm       = Di;
            st_d            = S_OPCODE;
          end
          else
            st_d = S_IMM_HI;
        end
        S_IMM_HI:
        begin
          // jump target, high byte on the bus now
          pc_d = {Di, imm_lo_q};
          st_d = S_OPCODE;
        end
        default:
          st_d = st_q;
      endcase
    end
    else if (st_q == S_START)
      st_d = S_OPCODE;
  end

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      st_q      <= S_START;
      pc_q      <= RESET_PC;
      uop_valid <= 1'b0;
    end
    else
    begin
      st_q <= st_d;
      pc_q <= pc_d;
      // hold the issued op until execute takes it
      if (!exec_stall)
        uop_valid <= issue;
    end
  end

  // byte collectors and the uop payload
  always_ff @(posedge clock)
  begin
    if (fetch_en && st_q == S_OPCODE)
      op_q <= op_in;
    if (fetch_en && st_q == S_IMM_LO)
      imm_lo_q <= Di;
    if (!exec_stall && issue)
      uop <= uop_d;
  end

  // a stalled uop is presented again unchanged
  a_uop_hold : assert property (@(posedge clock) disable iff (!arst_n)
    uop_valid && exec_stall |=> uop_valid && $stable(uop));

endmodule

/* hw/sm83_execute.sv */
// operand select with bypassed reads, SM83 ALU and flag logic,
// and the register into the result stage

`timescale 1ns/100ps

module sm83_execute
  import cpu_isa_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  uop_t       uop,
  input  logic       uop_valid,
  input  logic [7:0] rd_a,
  input  logic [7:0] rd_src,
  input  logic [7:0] f_in,
  input  logic       bus_busy,
  output reg_idx_t   rd_src_idx,
  output logic       exec_stall,
  output exec_res_t  res,
  output logic       res_valid
);

  logic [7:0] op_a;
  logic [7:0] op_b;
  logic [7:0] alu_r;
  logic [8:0] sum9;
  logic [4:0] sum5;
  logic [8:0] diff9;
  logic       fz, fn, fh, fc;
  logic       mem_wait;
  exec_res_t  res_d;

  assign rd_src_idx = uop.src;

  // A is the left operand, right operand from imm or the source register
  assign op_a = rd_a;
  assign op_b = uop.imm_valid ? uop.imm : rd_src;

  assign sum9  = {1'b0, op_a} + {1'b0, op_b};
  assign sum5  = {1'b0, op_a[3:0]} + {1'b0, op_b[3:0]};
  assign diff9 = {1'b0, op_a} - {1'b0, op_b};

  // an (HL) op waiting in result blocks the next op until its access is done
  assign mem_wait   = res_valid && (res.mem_rd || res.mem_wr);
  assign exec_stall = bus_busy || mem_wait;

  always_comb
  begin
    alu_r = op_b;
    fn    = 1'b0;
    fh    = 1'b0;
    // INC and DEC leave carry alone
    fc    = f_in[FLAG_C];
    case (uop.alu)
      ALU_ADD:
      begin
        alu_r = sum9[7:0];
        fh    = sum5[4];
        fc    = sum9[8];
      end
      ALU_SUB, ALU_CP:
      begin
        alu_r = diff9[7:0];
        fn    = 1'b1;
        fh    = (op_a[3:0] < op_b[3:0]);
        fc    = diff9[8];
      end
      ALU_AND:
      begin
        alu_r = op_a & op_b;
        fh    = 1'b1;
        fc    = 1'b0;
      end
      ALU_XOR:
      begin
        alu_r = op_a ^ op_b;
        fc    = 1'b0;
      end
      ALU_OR:
      begin
        alu_r = op_a | op_b;
        fc    = 1'b0;
      end
      ALU_INC:
      begin
        alu_r = op_b + 8'd1;
        fh    = (op_b[3:0] == 4'hF);
      end
      ALU_DEC:
      begin
        alu_r = op_b - 8'd1;
        fn    = 1'b1;
        fh    = (op_b[3:0] == 4'h0);
      end
      default:
        alu_r = op_b;
    endcase
    fz = (alu_r == 8'h00);
  end

  always_comb
  begin
    res_d.dst    = uop.dst;
    // CP and stores leave the register file alone
    res_d.we     = (uop.alu != ALU_CP) && !uop.mem_wr;
    res_d.value  = alu_r;
    res_d.f      = {fz, fn, fh, fc, 4'h0};
    res_d.f_we   = (uop.alu != ALU_PASS);
    res_d.mem_rd = uop.mem_rd;
    res_d.mem_wr = uop.mem_wr;
  end

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      res_valid <= 1'b0;
    else if (!bus_busy)
      res_valid <= uop_valid && !mem_wait;
  end

  always_ff @(posedge clock)
  begin
    if (!exec_stall && uop_valid)
      res <= res_d;
  end

  // decode never marks one op as both load and store
  a_one_dir : assert property (@(posedge clock) disable iff (!arst_n)
    uop_valid |-> !(uop.mem_rd && uop.mem_wr));

endmodule

/* hw/sm83_result.sv */
// register file with bypassed read ports, (HL) bus access
// and writeback of ALU and load results

`timescale 1ns/100ps

module sm83_result
  import cpu_isa_pkg::*;
  import board_bus_pkg::*;
(
  input  logic        clock,
  input  logic        arst_n,
  input  exec_res_t   res,
  input  logic        res_valid,
  input  logic [7:0]  Di,
  input  reg_idx_t    rd_src_idx,
  output mem_req_t    data_req,
  output logic        bus_busy,
  output logic [7:0]  rd_a,
  output logic [7:0]  rd_src,
  output logic [7:0]  f_out,
  output logic [15:0] af,
  output logic [15:0] bc,
  output logic [15:0] de,
  output logic [15:0] hl
);

  logic [7:0] regs [8];
  logic [7:0] f_reg;
  exec_res_t  held;
  logic       held_valid;
  logic       res_is_mem;
  logic       wr_pend;
  logic       f_pend;

  assign res_is_mem = res.mem_rd || res.mem_wr;
  assign wr_pend    = res_valid && res.we && !res_is_mem;
  assign f_pend     = res_valid && res.f_we;

  // read with the pending writeback folded in
  function automatic logic [7:0] read_port(input reg_idx_t idx);
    if (wr_pend && res.dst == idx)
      return res.value;
    return regs[idx];
  endfunction

  always_comb
  begin
    rd_a   = read_port(REG_A);
    rd_src = read_port(rd_src_idx);
    f_out  = f_pend ? {res.f[7:4], 4'h0} : f_reg;
  end

  assign af = {regs[REG_A], f_reg};
  assign bc = {regs[REG_B], regs[REG_C]};
  assign de = {regs[REG_D], regs[REG_E]};
  assign hl = {regs[REG_H], regs[REG_L]};

  // held (HL) op owns the bus for one cycle
  assign bus_busy       = held_valid;
  assign data_req.addr  = hl;
  assign data_req.wdata = held.value;
  assign data_req.rd    = held_valid && held.mem_rd;
  assign data_req.wr    = held_valid && held.mem_wr;

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      held_valid <= 1'b0;
    else
      held_valid <= res_valid && res_is_mem && !held_valid;
  end

  always_ff @(posedge clock)
  begin
    if (res_valid && res_is_mem && !held_valid)
      held <= res;
  end

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= 8'h00;
      f_reg <= 8'h00;
    end
    else
    begin
      if (wr_pend)
        regs[res.dst] <= res.value;
      if (f_pend)
        f_reg <= {res.f[7:4], 4'h0};
      // LD A,(HL) lands at the end of the bus cycle
      if (held_valid && held.mem_rd)
        regs[held.dst] <= Di;
    end
  end

  // programs keep H pointing into work RAM
  a_hl_in_wram : assert property (@(posedge clock) disable iff (!arst_n)
    (data_req.rd || data_req.wr) |-> data_req.addr[WRAM_SEL_BIT]);

endmodule

/* hw/work_ram.sv */
// work RAM, combinational read and write on the clock edge

`timescale 1ns/100ps

module work_ram
  import board_bus_pkg::*;
(
  input  logic        clock,
  input  logic [12:0] addr,
  input  logic [7:0]  wdata,
  input  logic        wr_cs,
  input  logic        rd_cs,
  output logic [7:0]  rdata
);

  logic [7:0] mem [WRAM_DEPTH];

  always_ff @(posedge clock)
  begin
    if (wr_cs)
      mem[addr] <= wdata;
  end

  // deselected read floats low for the data mux
  assign rdata = rd_cs ? mem[addr] : 8'h00;

endmodule

/* run_sim.sh */
#!/bin/sh
# build the gb_lite testbench with Verilator, run it, and check for a clean finish

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -Mdir build \
  --top-module gb_lite_tb -f gb_lite.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./build/Vgb_lite_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi

echo "simulation did not report a clean finish"
exit 1
